/* all.f */
source/socPkg.sv
source/resetSync.sv
source/instrFetch.sv
source/instrDecode.sv
source/execStage.sv
source/gpioBlock.sv
source/apbUncore.sv
source/miniSoc.sv
bench/miniSocTb.sv

/* bench/miniSocTb.sv */
`timescale 1ns/1ps

module miniSocTb;

  localparam int MaxTests   = 64;
  localparam int RecWords   = 5;   // Hex words per line of the tests file
  localparam int WaitCycles = 40;  // Watchdog budget per record

  // One line of the tests file
  typedef struct packed {
    socPkg::instrT instr;
    socPkg::dataT  gpioIn;      // Pin value applied with the instruction
    socPkg::dataT  expData;
    logic          expErr;
    socPkg::dataT  expGpioEn;   // Pin state after the retirement
    socPkg::dataT  expGpioOut;
  } testRecT;

  logic           clk = 1'b0;
  logic           rstN;
  logic           instrValid;
  socPkg::instrT  instr;
  logic           instrReady;
  socPkg::dataT   gpioIn;
  socPkg::dataT   gpioOut;
  socPkg::dataT   gpioEn;
  logic           retireValid;
  socPkg::retireT retire;

  logic [15:0] testWords [RecWords*MaxTests];  // Raw file image
  testRecT     tests [MaxTests];
  int          numTests    = 0;
  int          retireCount = 0;   // Retirements seen so far

  miniSoc #(.RAM_DEPTH(16)) i_miniSoc (
    .clk, .rstN, .instrValid, .instr, .instrReady, .gpioIn, .gpioOut, .gpioEn,
    .retireValid, .retire
  );

  always #4 clk = ~clk;  // 8 ns period

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Fill with bit 15 set marks unused words since error flags are 0 or 1
  task automatic loadTests();
    int base;
    for (int a = 0; a < RecWords*MaxTests; a++) begin
      testWords[a] = 16'h8000 | 16'(a);
    end
    $readmemh("bench/socTests.txt", testWords);
    numTests = 0;
    while (numTests < MaxTests && testWords[RecWords*numTests + 3] <= 16'h0001) begin
      base = RecWords*numTests;
      tests[numTests].instr      = testWords[base];
      tests[numTests].gpioIn     = testWords[base + 1][7:0];
      tests[numTests].expData    = testWords[base + 2][7:0];
      tests[numTests].expErr     = testWords[base + 3][0];
      tests[numTests].expGpioEn  = testWords[base + 4][15:8];
      tests[numTests].expGpioOut = testWords[base + 4][7:0];
      numTests++;
    end
  endtask

  // Random idle gap then an offer held until the fetch buffer takes it
  task automatic sendInstr(input testRecT rec);
    int gap;
    gap = $urandom % 4;
    repeat (gap) begin
      instrValid <= 1'b0;
      @(posedge clk);
    end
    instrValid <= 1'b1;
    instr      <= rec.instr;
    gpioIn     <= rec.gpioIn;
    do @(negedge clk); while (!instrReady);  // Ready settles mid cycle
    @(posedge clk);                           // Transfer edge
  endtask

  task automatic checkValue(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("Error at %0t ns: %s expected %02h, actual %02h", $time, name, expected, actual);
      $display("test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : driver
    instrValid = 1'b0;
    instr      = '0;
    gpioIn     = '0;
    rstN       = 1'b0;
    void'($urandom(39));
    loadTests();
    assert (numTests > 0) else begin
      $display("No test records could be read from the tests file");
      $display("test failed");
      $fatal(1, "Empty test set");
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    checkValue("instrReady", 8'h00, 8'(instrReady));  // Held off in reset
    @(posedge clk);
    rstN <= 1'b1;
    repeat (2) @(posedge clk);  // Internal reset just released
    @(negedge clk);
    checkValue("instrReady", 8'h01, 8'(instrReady));  // Empty buffer takes work
    checkValue("retireValid", 8'h00, 8'(retireValid));
    checkValue("gpioOut", 8'h00, gpioOut);
    checkValue("gpioEn", 8'h00, gpioEn);
    @(posedge clk);
    for (int i = 0; i < numTests; i++) begin
      sendInstr(tests[i]);
    end
    instrValid <= 1'b0;
    while (retireCount < numTests) @(negedge clk);
    repeat (10) @(negedge clk);  // Room for a stray extra retirement
    if (retireCount == numTests) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Retired %0d instructions for %0d test records", retireCount, numTests);
      $display("test failed");
      $fatal(1, "Retirement count mismatch");
    end
  end

  // In-order retirement checker
  initial begin : monitor
    testRecT             rec;
    socPkg::instrFieldsT fields;
    socPkg::regIdxT      expIdx;
    forever begin
      @(negedge clk);
      if (retireValid === 1'b1) begin
        assert (retireCount < numTests) else begin
          $display("An instruction retired beyond the last test record at %0t ns", $time);
          $display("test failed");
          $fatal(1, "Extra retirement");
        end
        rec    = tests[retireCount];
        fields = rec.instr;
        expIdx = (fields.op == socPkg::OpStore) ? fields.rs : fields.rd;  // STORE traces rs
        checkValue("retire.regIdx", 8'(expIdx), 8'(retire.regIdx));
        checkValue("retire.data", rec.expData, retire.data);
        checkValue("retire.err", 8'(rec.expErr), 8'(retire.err));
        checkValue("gpioOut", rec.expGpioOut, gpioOut);
        checkValue("gpioEn", rec.expGpioEn, gpioEn);
        retireCount++;
      end
    end
  end

  // Run length scales with the number of records
  initial begin : watchdog
    int limit;
    #1;
    limit = (numTests + 1) * WaitCycles;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d instructions retired",
             limit, retireCount, numTests);
    $display("test failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* bench/socTests.txt */
// instr  gpioIn  retire-data  error-flag  {gpioEn,gpioOut} after retirement
// LOAD and STORE carry the APB address in the low byte; registers start at zero
4000 00 00 0 0000
5400 00 00 0 0000
6800 00 00 0 0000
7C00 00 00 0 0000
0005 00 05 0 0000
10F0 00 F0 0 0000
5000 00 F5 0 0000
5400 00 EA 0 0000
4400 00 EF 0 0000
4000 00 DE 0 0000
8403 00 EA 0 0000
E003 00 EA 0 0000
800F 5A DE 0 0000
F00F 5A DE 0 0000
8410 5A EA 0 00EA
303C 5A 3C 0 00EA
8C11 5A 3C 0 3CEA
E012 5A 5A 0 3CEA
C010 5A EA 0 3CEA
8812 5A 5A 1 3CEA
D020 5A EA 1 3CEA
F0FF 5A 3C 1 3CEA
5C00 C3 26 0 3CEA
8C13 C3 3C 1 3CEA
C012 C3 C3 0 3CEA
8010 C3 C3 0 3CC3
8411 C3 26 0 26C3
F003 C3 EA 0 26C3
7000 C3 AD 0 26C3

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module miniSocTb -f all.f -o miniSocSim \
  > build.log 2>&1 && ./obj_dir/miniSocSim > sim.log 2>&1
cat sim.log 2>/dev/null || cat build.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

/* source/apbUncore.sv */
`timescale 1ns/1ps

module apbUncore #(
  parameter int RAM_DEPTH = 16  // Scratch RAM words, 16 at most
) (
  input  logic           clk,
  input  logic           rstN,
  input  socPkg::apbReqT apbReq,
  output socPkg::apbRspT apbRsp,
  input  socPkg::dataT   gpioIn,
  output socPkg::dataT   gpioOut,
  output socPkg::dataT   gpioEn
);

  socPkg::addrT   ramOffset;
  logic [3:0]     ramIdx;
  logic           ramSel, gpioSel, errSel;
  logic           ramWait;          // First access cycle done
  socPkg::dataT   ram [RAM_DEPTH];  // Contents not reset
  socPkg::apbRspT gpioRsp;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign ramOffset = apbReq.paddr - socPkg::RamBaseAddr;
  assign ramIdx    = ramOffset[3:0];
  assign ramSel    = apbReq.psel && (ramOffset < RAM_DEPTH);
  assign gpioSel   = apbReq.psel && ((apbReq.paddr == socPkg::GpioOutAddr) ||
                                     (apbReq.paddr == socPkg::GpioEnAddr)  ||
                                     (apbReq.paddr == socPkg::GpioInAddr));
  assign errSel    = apbReq.psel && !ramSel && !gpioSel;  // Hole in the map

  // One wait state, toggles across the two access cycles
  always_ff @(posedge clk) begin
    if (!rstN) ramWait <= 1'b0;
    else if (ramSel && apbReq.penable) ramWait <= !ramWait;
  end

  always_ff @(posedge clk) begin
    if (ramSel && apbReq.penable && ramWait && apbReq.pwrite) begin
      ram[ramIdx] <= apbReq.pwdata;  // Write lands on the ready cycle
    end
  end

  gpioBlock i_gpioBlock (
    .clk, .rstN, .psel(gpioSel), .apbReq, .apbRsp(gpioRsp), .gpioIn, .gpioOut, .gpioEn
  );

  // Response mux
  always_comb begin
    apbRsp = '0;
    if (ramSel) begin
      apbRsp.prdata = ram[ramIdx];
      apbRsp.pready = ramWait;
    end else if (gpioSel) begin
      apbRsp = gpioRsp;
    end else if (errSel) begin
      apbRsp.pready  = apbReq.penable;
      apbRsp.pslverr = apbReq.penable;
    end
  end

  assert property (@(posedge clk) disable iff (!rstN) $onehot0({ramSel, gpioSel, errSel}));

endmodule

/* source/execStage.sv */
`timescale 1ns/1ps

module execStage (
  input  logic           clk,
  input  logic           rstN,
  // From decode
  input  logic           dValid,
  input  socPkg::decOpT  dOp,
  output logic           xReady,
  // APB master
  output socPkg::apbReqT apbReq,
  input  socPkg::apbRspT apbRsp,
  // Retire trace
  output logic           retireValid,
  output socPkg::retireT retire
);

  typedef enum logic [1:0] {Idle, Setup, Access} stateT;

  stateT          state;
  socPkg::dataT   regs [4];    // Register file
  socPkg::decOpT  busOp;       // Operation owning the bus
  socPkg::dataT   aluResult;
  socPkg::retireT busRetire;

  // LOADI passes imm, ADD wraps at 8 bits
  assign aluResult = (dOp.op == socPkg::OpLoadi) ? dOp.imm : regs[dOp.rd] + regs[dOp.rs];

  // Register file is quiet during a transfer, so rs drives pwdata directly
  assign apbReq.psel    = (state != Idle);
  assign apbReq.penable = (state == Access);
  assign apbReq.pwrite  = (busOp.op == socPkg::OpStore);
  assign apbReq.paddr   = busOp.imm;
  assign apbReq.pwdata  = regs[busOp.rs];

  assign xReady = (state == Idle);  // No new work while the bus is open

  // Trace for a finishing bus operation
  always_comb begin
    busRetire.err = apbRsp.pslverr;
    if (busOp.op == socPkg::OpLoad) begin
      busRetire.regIdx = busOp.rd;
      busRetire.data   = apbRsp.pslverr ? regs[busOp.rd] : apbRsp.prdata;  // Old rd on error
    end else begin
      busRetire.regIdx = busOp.rs;
      busRetire.data   = regs[busOp.rs];  // Stored value
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM, register writes and retire
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= Idle;
      retireValid <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        regs[i] <= '0;
      end
    end else begin
      retireValid <= 1'b0;  // Single-cycle pulse
      case (state)
        Idle: begin
          if (dValid && dOp.isBus) begin
            busOp <= dOp;
            state <= Setup;
          end else if (dValid) begin
            regs[dOp.rd] <= aluResult;
            retireValid  <= 1'b1;
            retire       <= '{regIdx: dOp.rd, data: aluResult, err: 1'b0};
          end
        end
        Setup: state <= Access;  // Exactly one setup cycle
        Access: begin
          if (apbRsp.pready) begin
            state       <= Idle;
            retireValid <= 1'b1;
            retire      <= busRetire;
            if (busOp.op == socPkg::OpLoad && !apbRsp.pslverr) begin
              regs[busOp.rd] <= apbRsp.prdata;
            end
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // Address, direction and data hold from setup until the slave is ready
  assert property (@(posedge clk) disable iff (!rstN)
    (apbReq.psel && !(apbReq.penable && apbRsp.pready)) |=>
      (apbReq.psel && $stable({apbReq.paddr, apbReq.pwrite, apbReq.pwdata})));

endmodule

/* source/gpioBlock.sv */
`timescale 1ns/1ps

module gpioBlock (
  input  logic           clk,
  input  logic           rstN,
  input  logic           psel,     // Select from the uncore decoder
  input  socPkg::apbReqT apbReq,
  output socPkg::apbRspT apbRsp,
  input  socPkg::dataT   gpioIn,
  output socPkg::dataT   gpioOut,
  output socPkg::dataT   gpioEn
);

  logic         access;    // Access phase aimed at us
  logic         wrInReg;   // Illegal write to the input register
  socPkg::dataT inSample;  // gpioIn seen last edge

  assign access  = psel && apbReq.penable;
  assign wrInReg = apbReq.pwrite && (apbReq.paddr == socPkg::GpioInAddr);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      gpioOut <= '0;
      gpioEn  <= '0;
    end else if (access && apbReq.pwrite) begin
      if (apbReq.paddr == socPkg::GpioOutAddr) gpioOut <= apbReq.pwdata;
      if (apbReq.paddr == socPkg::GpioEnAddr)  gpioEn  <= apbReq.pwdata;
    end
  end

  always_ff @(posedge clk) begin
    inSample <= gpioIn;  // Sampled every cycle
  end

  // Zero wait states
  always_comb begin
    apbRsp.pready  = access;
    apbRsp.pslverr = access && wrInReg;
    case (apbReq.paddr)
      socPkg::GpioOutAddr: apbRsp.prdata = gpioOut;
      socPkg::GpioEnAddr:  apbRsp.prdata = gpioEn;
      socPkg::GpioInAddr:  apbRsp.prdata = inSample;
      default:             apbRsp.prdata = '0;
    endcase
  end

endmodule

/* source/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
  input  logic          clk,
  input  logic          rstN,
  // From fetch
  input  logic          fValid,
  input  socPkg::instrT fInstr,
  output logic          dReady,
  // Toward execute
  output logic          dValid,
  output socPkg::decOpT dOp,
  input  logic          xReady
);

  socPkg::instrFieldsT fields;  // Raw instruction viewed by field
  socPkg::decOpT       nextOp;
  logic                valid;

  assign fields = fInstr;

  // Crack the instruction
  always_comb begin
    nextOp.op    = fields.op;
    nextOp.rd    = fields.rd;
    nextOp.rs    = fields.rs;
    nextOp.imm   = fields.imm;
    nextOp.isBus = (fields.op == socPkg::OpStore) || (fields.op == socPkg::OpLoad);
  end

  assign dReady = !valid || xReady;  // Slot empty or being taken

  always_ff @(posedge clk) begin
    if (!rstN) begin
      valid <= 1'b0;
    end else if (dReady) begin
      valid <= fValid;
    end
  end

  always_ff @(posedge clk) begin
    if (dReady && fValid) dOp <= nextOp;  // Payload
  end

  assign dValid = valid;

  // Execute stalled: operation must hold
  assert property (@(posedge clk) disable iff (!rstN)
    (dValid && !xReady) |=> $stable(dOp));

endmodule

/* source/instrFetch.sv */
`timescale 1ns/1ps

module instrFetch (
  input  logic          clk,
  input  logic          rstN,
  // Outside instruction port
  input  logic          instrValid,
  input  socPkg::instrT instr,
  output logic          instrReady,
  // Toward decode
  output logic          fValid,
  output socPkg::instrT fInstr,
  input  logic          dReady
);

  logic          full;       // Buffer holds an instruction
  logic          load;       // Handshake on the outside port
  socPkg::instrT bufInstr;

  // Room out of reset when empty or when decode drains us this cycle
  assign instrReady = rstN && (!full || dReady);
  assign load       = instrValid && instrReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      full <= 1'b0;
    end else begin
      if (load) full <= 1'b1;           // Refill, even while draining
      else if (dReady) full <= 1'b0;    // Taken by decode
    end
  end

  always_ff @(posedge clk) begin
    if (load) bufInstr <= instr;  // Payload, no reset
  end

  assign fValid = full;
  assign fInstr = bufInstr;

  // Held entry must survive a stall untouched
  assert property (@(posedge clk) disable iff (!rstN)
    (full && !dReady) |=> (full && $stable(bufInstr)));

endmodule

/* source/miniSoc.sv */
`timescale 1ns/1ps

module miniSoc #(
  parameter int RAM_DEPTH = 16
) (
  input  logic           clk,
  input  logic           rstN,         // External reset pin
  // Instruction port
  input  logic           instrValid,
  input  socPkg::instrT  instr,
  output logic           instrReady,
  // GPIO pins
  input  socPkg::dataT   gpioIn,
  output socPkg::dataT   gpioOut,
  output socPkg::dataT   gpioEn,
  // Retire trace
  output logic           retireValid,
  output socPkg::retireT retire
);

  logic           coreRstN;      // Synchronized reset
  logic           fValid, dReady;
  socPkg::instrT  fInstr;
  logic           dValid, xReady;
  socPkg::decOpT  dOp;
  socPkg::apbReqT apbReq;
  socPkg::apbRspT apbRsp;

  resetSync i_resetSync (.clk, .rstN, .syncRstN(coreRstN));

  ////////////////////////////////////////////////////////////////////////////
  // Core pipeline
  ////////////////////////////////////////////////////////////////////////////

  instrFetch i_instrFetch (
    .clk, .rstN(coreRstN), .instrValid, .instr, .instrReady, .fValid, .fInstr, .dReady
  );

  instrDecode i_instrDecode (
    .clk, .rstN(coreRstN), .fValid, .fInstr, .dReady, .dValid, .dOp, .xReady
  );

  execStage i_execStage (
    .clk, .rstN(coreRstN), .dValid, .dOp, .xReady, .apbReq, .apbRsp, .retireValid, .retire
  );

  // Memory and peripherals
  apbUncore #(.RAM_DEPTH(RAM_DEPTH)) i_apbUncore (
    .clk, .rstN(coreRstN), .apbReq, .apbRsp, .gpioIn, .gpioOut, .gpioEn
  );

endmodule

/* source/resetSync.sv */
`timescale 1ns/1ps

module resetSync (
  input  logic clk,
  input  logic rstN,      // Raw external reset
  output logic syncRstN   // Clean internal reset
);

  logic [1:0] syncChain;  // Shifts in ones once rstN is high

  // Assert at once, release two edges later
  always_ff @(posedge clk) begin
    if (!rstN) begin
      syncChain <= 2'b00;
    end else begin
      syncChain <= {syncChain[0], 1'b1};
    end
  end

  assign syncRstN = syncChain[1];

endmodule

/* source/socPkg.sv */
package socPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [7:0]  dataT;    // Register, bus and GPIO word
  typedef logic [7:0]  addrT;    // APB address
  typedef logic [1:0]  regIdxT;  // One of four registers
  typedef logic [15:0] instrT;   // Raw instruction

  // Opcodes, two bits at the top of the instruction
  typedef enum logic [1:0] {
    OpLoadi = 2'd0,  // rd <= imm
    OpAdd   = 2'd1,  // rd <= rd + rs
    OpStore = 2'd2,  // mem[imm] <= rs
    OpLoad  = 2'd3   // rd <= mem[imm]
  } opT;

  // Raw instruction layout, MSB first
  typedef struct packed {
    opT     op;
    regIdxT rd;
    regIdxT rs;
    logic [1:0] spare;  // Reserved, ignored by decode
    dataT   imm;        // Immediate or bus address
  } instrFieldsT;

  // Decoded operation handed to execute
  typedef struct packed {
    opT     op;
    regIdxT rd;
    regIdxT rs;
    dataT   imm;
    logic   isBus;  // STORE or LOAD
  } decOpT;

  ////////////////////////////////////////////////////////////////////////////
  // APB and trace bundles
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic psel;
    logic penable;
    logic pwrite;
    addrT paddr;
    dataT pwdata;
  } apbReqT;

  typedef struct packed {
    dataT prdata;
    logic pready;
    logic pslverr;
  } apbRspT;

  typedef struct packed {
    regIdxT regIdx;
    dataT   data;
    logic   err;   // Bus error on this instruction
  } retireT;

  // Address map
  localparam addrT RamBaseAddr = 8'h00;
  localparam addrT GpioOutAddr = 8'h10;
  localparam addrT GpioEnAddr  = 8'h11;
  localparam addrT GpioInAddr  = 8'h12;  // Read only

endpackage
